// ==== hw/wiscCfg.svh ====
/*
   Front end sizing. The ISA fixes a 16-bit word and 8 registers,
   so only the memory depth and reset PC are safe to change
*/
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// Data and instruction width in bits
`define WORD_W 16

// Number of architectural registers
`define REG_CNT 8

// Instruction memory size in 16-bit words
`define IMEM_DEPTH 64

// First PC after reset
`define RESET_PC 16'h0000

`endif

// ==== hw/isaPkg.sv ====
/*
   WISC instruction word layout. Only opcodes the front end acts on are named
   and any other code decodes as an ordinary instruction
*/
package isaPkg;

   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,                 // PC-relative jump with 11-bit displacement
      opJr    = 5'b00101,                 // Register jump
      opJal   = 5'b00110,                 // Links into R7
      opJalr  = 5'b00111,
      opXori  = 5'b01010,                 // Logical immediates are zero extended
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opLbi   = 5'b11000
   } opcodeT;

   // I format with a 5-bit immediate
   typedef struct packed {
      opcodeT     op;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } iFmtT;

   // Branches, JR, JALR and LBI carry an 8-bit immediate after rs
   typedef struct packed {
      opcodeT     op;
      logic [2:0] rs;
      logic [7:0] imm;
   } biFmtT;

   // J and JAL
   typedef struct packed {
      opcodeT      op;
      logic [10:0] disp;
   } jFmtT;

   // Three register format
   typedef struct packed {
      opcodeT     op;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] fn;                     // Selects the operation inside an opcode group
   } rFmtT;

   // The opcode sits in bits 15:11 of every view
   typedef union packed {
      iFmtT  iFmt;
      biFmtT biFmt;
      jFmtT  jFmt;
      rFmtT  rFmt;
   } instrU;

endpackage

// ==== hw/pipePkg.sv ====
/*
   Bundles passed between fetch, decode and the later stages.
   Valid qualifies each bundle and there is no back-pressure
*/
`include "wiscCfg.svh"

package pipePkg;
   import isaPkg::*;

   localparam int regAddrW  = $clog2(`REG_CNT);
   localparam int imemAddrW = $clog2(`IMEM_DEPTH);

   // Byte step between sequential instructions
   localparam logic [`WORD_W-1:0] instrBytes = `WORD_W'(2);

   typedef struct packed {
      logic               valid;
      instrU              instr;
      logic [`WORD_W-1:0] pc;
   } fetchOutT;

   typedef struct packed {
      logic               valid;
      instrU              instr;
      logic [`WORD_W-1:0] rsData;
      logic [`WORD_W-1:0] rtData;
      logic [`WORD_W-1:0] imm;            // Already extended for the format
      logic [`WORD_W-1:0] pcPlus2;        // Own PC+2 and also the link value
   } decodeOutT;

   typedef enum logic [1:0] {
      srcAlu,
      srcImm,
      srcLink
   } wbSrcT;

   // One register write returned by the later stages
   typedef struct packed {
      logic                en;
      logic [regAddrW-1:0] addr;
      wbSrcT               src;
      logic [`WORD_W-1:0]  aluData;
      logic [`WORD_W-1:0]  imm;
      logic [`WORD_W-1:0]  pcPlus2;
   } wbT;

   typedef struct packed {
      logic                 en;
      logic [imemAddrW-1:0] addr;         // Word address
      logic [`WORD_W-1:0]   data;
   } imemWrT;

endpackage

// ==== hw/regFile.sv ====
/*
   Eight general registers. R0 is an ordinary register and not tied to zero.
   A write shows on both read ports in the same cycle
*/
`timescale 1ns/100ps
`include "wiscCfg.svh"

module regFile import pipePkg::*; (
   input  logic                clk,
   input  logic                rstN,
   input  logic [regAddrW-1:0] rdAddrA,
   input  logic [regAddrW-1:0] rdAddrB,
   input  logic                wrEn,
   input  logic [regAddrW-1:0] wrAddr,
   input  logic [`WORD_W-1:0]  wrData,
   output logic [`WORD_W-1:0]  rdDataA,
   output logic [`WORD_W-1:0]  rdDataB
);

   logic [`WORD_W-1:0] regs [`REG_CNT];
   logic               hitA;
   logic               hitB;

   // All registers start at zero so programs see a known state
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Bypass the write port when it targets the register being read
   assign hitA = wrEn && (wrAddr == rdAddrA);
   assign hitB = wrEn && (wrAddr == rdAddrB);

   assign rdDataA = hitA ? wrData : regs[rdAddrA];
   assign rdDataB = hitB ? wrData : regs[rdAddrB];  // Same rule as port A

endmodule

// ==== hw/immExtend.sv ====
/*
   Immediate extraction for every WISC format. Codes not named in isaPkg
   are treated as 5-bit signed I format
*/
`timescale 1ns/100ps
`include "wiscCfg.svh"

module immExtend import isaPkg::*; (
   input  instrU              instr,
   output logic [`WORD_W-1:0] imm
);

   logic [`WORD_W-1:0] imm5Zero;
   logic [`WORD_W-1:0] imm5Sign;
   logic [`WORD_W-1:0] imm8Sign;
   logic [`WORD_W-1:0] disp11Sign;

   // Every format is extended up front and the opcode picks one below
   assign imm5Zero   = {{(`WORD_W-5){1'b0}}, instr.iFmt.imm};
   assign imm5Sign   = {{(`WORD_W-5){instr.iFmt.imm[4]}}, instr.iFmt.imm};
   assign imm8Sign   = {{(`WORD_W-8){instr.biFmt.imm[7]}}, instr.biFmt.imm};
   assign disp11Sign = {{(`WORD_W-11){instr.jFmt.disp[10]}}, instr.jFmt.disp};

   always_comb begin
      case (instr.iFmt.op)
         opXori, opAndni: begin
            imm = imm5Zero;                     // Logical ops keep the upper bits clear
         end
         opBeqz, opBnez, opBltz, opBgez, opJr, opJalr, opLbi: begin
            imm = imm8Sign;
         end
         opJ, opJal: begin
            imm = disp11Sign;                   // Byte displacement from PC+2
         end
         default: begin
            imm = imm5Sign;
         end
      endcase
   end

endmodule

// ==== hw/fetchStage.sv ====
/*
   PC, loadable instruction memory and the IF/ID register.
   The PC is a byte address and the memory wraps above IMEM_DEPTH words
*/
`timescale 1ns/100ps
`include "wiscCfg.svh"

module fetchStage import isaPkg::*, pipePkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  logic               run,
   input  imemWrT             imemWr,
   input  logic               redirect,
   input  logic [`WORD_W-1:0] target,
   input  logic               halted,
   output fetchOutT           ifOut
);

   logic [`WORD_W-1:0] imem [`IMEM_DEPTH];
   logic [`WORD_W-1:0] pc;
   logic [`WORD_W-1:0] pcPlus2;
   logic [`WORD_W-1:0] nextPc;
   logic               fetchEn;
   logic               ifValid;
   instrU              ifInstr;
   logic [`WORD_W-1:0] ifPc;

   // External load port, usable at any time
   always_ff @(posedge clk) begin
      if (imemWr.en) begin
         imem[imemWr.addr] <= imemWr.data;
      end
   end

   assign fetchEn = run && !halted;              // Halt freezes the PC for good
   assign pcPlus2 = pc + instrBytes;
   assign nextPc  = redirect ? target : pcPlus2;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc      <= `RESET_PC;
         ifValid <= 1'b0;
      end else begin
         // A redirect squashes the word fetched alongside it
         ifValid <= fetchEn && !redirect;
         if (fetchEn) begin
            pc <= nextPc;
         end
      end
   end

   // Word index drops the byte bit of the PC
   always_ff @(posedge clk) begin
      if (fetchEn) begin
         ifInstr <= imem[pc[imemAddrW:1]];
         ifPc    <= pc;
      end
   end

   assign ifOut = '{valid: ifValid, instr: ifInstr, pc: ifPc};

endmodule

// ==== hw/decodeStage.sv ====
/*
   Decode with register reads, writeback select and branch resolution.
   Control transfers resolve here and cost one squashed fetch slot.
   The word behind HALT is dropped while fetch is still winding down
*/
`timescale 1ns/100ps
`include "wiscCfg.svh"

module decodeStage import isaPkg::*, pipePkg::*; (
   input  logic               clk,
   input  logic               rstN,
   input  fetchOutT           ifOut,
   input  wbT                 wb,
   output logic               redirect,
   output logic [`WORD_W-1:0] target,
   output logic               halted,
   output decodeOutT          decOut
);

   opcodeT              op;
   logic [regAddrW-1:0] rsAddr;
   logic [regAddrW-1:0] rtAddr;
   logic [`WORD_W-1:0]  rsData;
   logic [`WORD_W-1:0]  rtData;
   logic [`WORD_W-1:0]  imm;
   logic [`WORD_W-1:0]  pcPlus2;
   logic [`WORD_W-1:0]  wrData;
   logic                live;
   logic                pcRelTaken;
   logic                regJump;
   logic                decValid;
   instrU               decInstr;
   logic [`WORD_W-1:0]  decRsData;
   logic [`WORD_W-1:0]  decRtData;
   logic [`WORD_W-1:0]  decImm;
   logic [`WORD_W-1:0]  decPcPlus2;

   assign op     = ifOut.instr.rFmt.op;
   assign rsAddr = ifOut.instr.rFmt.rs;           // Bits 10:8 in every format
   assign rtAddr = ifOut.instr.rFmt.rt;
   assign live   = ifOut.valid && !halted;        // Nothing past HALT is decoded

   // Write value comes from whichever later stage produced it
   always_comb begin
      case (wb.src)
         srcImm:  wrData = wb.imm;                // LBI
         srcLink: wrData = wb.pcPlus2;            // JAL and JALR return address
         default: wrData = wb.aluData;
      endcase
   end

   regFile uRegFile (.clk(clk), .rstN(rstN), .rdAddrA(rsAddr), .rdAddrB(rtAddr),
                     .wrEn(wb.en), .wrAddr(wb.addr), .wrData(wrData),
                     .rdDataA(rsData), .rdDataB(rtData));

   immExtend uImmExtend (.instr(ifOut.instr), .imm(imm));

   assign pcPlus2 = ifOut.pc + instrBytes;

   // Branch conditions look at rs only
   always_comb begin
      case (op)
         opBeqz:     pcRelTaken = (rsData == '0);
         opBnez:     pcRelTaken = (rsData != '0);
         opBltz:     pcRelTaken = rsData[`WORD_W-1];
         opBgez:     pcRelTaken = !rsData[`WORD_W-1];
         opJ, opJal: pcRelTaken = 1'b1;
         default:    pcRelTaken = 1'b0;
      endcase
   end

   assign regJump  = (op == opJr) || (op == opJalr);
   assign target   = regJump ? rsData + imm : pcPlus2 + imm;
   assign redirect = live && (pcRelTaken || regJump);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decValid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         decValid <= live;
         if (live && op == opHalt) begin
            halted <= 1'b1;                       // Sticky until reset
         end
      end
   end

   // ID/EX payload, qualified by decValid
   always_ff @(posedge clk) begin
      decInstr   <= ifOut.instr;
      decRsData  <= rsData;
      decRtData  <= rtData;
      decImm     <= imm;
      decPcPlus2 <= pcPlus2;
   end

   assign decOut = '{valid: decValid, instr: decInstr, rsData: decRsData,
                     rtData: decRtData, imm: decImm, pcPlus2: decPcPlus2};

endmodule

// ==== hw/wiscFrontEnd.sv ====
/*
   Fetch and decode of the WISC pipeline. The caller models execute and
   writeback and must accept every valid decOut word
*/
`timescale 1ns/100ps
`include "wiscCfg.svh"

module wiscFrontEnd import pipePkg::*; (
   input  logic      clk,
   input  logic      rstN,
   input  logic      run,                 // Held high once the program is loaded
   input  imemWrT    imemWr,
   input  wbT        wb,
   output decodeOutT decOut,
   output logic      halted
);

   fetchOutT           ifOut;
   logic               redirect;
   logic [`WORD_W-1:0] target;

   fetchStage uFetch (
      .clk      (clk),
      .rstN     (rstN),
      .run      (run),
      .imemWr   (imemWr),
      .redirect (redirect),               // Resolved one stage later in decode
      .target   (target),
      .halted   (halted),
      .ifOut    (ifOut)
   );

   decodeStage uDecode (
      .clk      (clk),
      .rstN     (rstN),
      .ifOut    (ifOut),
      .wb       (wb),
      .redirect (redirect),
      .target   (target),
      .halted   (halted),
      .decOut   (decOut)
   );

endmodule

// ==== tests/tbFrontEnd.sv ====
/*
   Front end testbench. It plays execute and writeback, keeps its own register
   and PC model, and checks every valid decOut word. Programs end in HALT
*/
`timescale 1ns/100ps
`include "wiscCfg.svh"

module tbFrontEnd import isaPkg::*, pipePkg::*;;

   localparam int testCnt = 6;
   localparam logic [4:0] addiOp = 5'b01000;    // I format ALU op
   localparam logic [4:0] addOp  = 5'b11011;    // R format ALU op

   logic      clk = 1'b0;
   logic      rstN;
   logic      run;
   imemWrT    imemWr;
   wbT        wb = '0;
   decodeOutT decOut;
   logic      halted;

   logic [15:0] progs [testCnt][`IMEM_DEPTH];
   int          lens [testCnt];
   string       names [testCnt];
   logic [15:0] prog [`IMEM_DEPTH];             // Program of the running test
   logic [15:0] mRegs [`REG_CNT];               // Register state after each edge
   logic [15:0] expPc;
   logic [15:0] lastPc2;                        // PC+2 and imm of the last checked word
   logic [15:0] lastImm;
   logic [15:0] pendVal;
   logic [15:0] aluVal;
   logic [15:0] w;
   logic [4:0]  op;
   decodeOutT   lastDec;
   logic        haltSeen;
   logic        setupDone = 1'b0;
   string       testName;
   integer      seed;
   int          errCnt = 0;
   int          passCnt = 0;
   int          failCnt = 0;
   int          wordCnt;

   wiscFrontEnd dut0 (.clk(clk), .rstN(rstN), .run(run), .imemWr(imemWr), .wb(wb),
                      .decOut(decOut), .halted(halted));

   initial begin
      forever #4 clk = ~clk;                    // 8 ns period
   end

   // Immediate extension as the ISA defines it per format
   function automatic logic [15:0] extImm(input logic [15:0] iw);
      case (iw[15:11])
         5'b01010, 5'b01011: return {11'b0, iw[4:0]};
         5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b00101, 5'b00111, 5'b11000:
            return {{8{iw[7]}}, iw[7:0]};
         5'b00100, 5'b00110: return {{5{iw[10]}}, iw[10:0]};
         default: return {{11{iw[4]}}, iw[4:0]};
      endcase
   endfunction

   // Next PC after a word, with rs seen through the bypass
   function automatic logic [15:0] nextPc(input logic [15:0] iw, input logic [15:0] pc,
                                          input logic [15:0] rsv);
      logic [15:0] pc2;
      pc2 = pc + 16'd2;
      case (iw[15:11])
         5'b01100: return (rsv == 16'd0) ? pc2 + extImm(iw) : pc2;
         5'b01101: return (rsv != 16'd0) ? pc2 + extImm(iw) : pc2;
         5'b01110: return rsv[15] ? pc2 + extImm(iw) : pc2;
         5'b01111: return !rsv[15] ? pc2 + extImm(iw) : pc2;
         5'b00100, 5'b00110: return pc2 + extImm(iw);
         5'b00101, 5'b00111: return rsv + extImm(iw);
         default: return pc2;
      endcase
   endfunction

   task automatic checkWord(input string field, input logic [15:0] exp, input logic [15:0] act);
      assert (exp === act) else begin
         $display("** Error %s %s: expected %h, actual %h", testName, field, exp, act);
         errCnt++;
      end
   endtask

   task automatic put(input int t, input logic [15:0] iw);
      progs[t][lens[t]] = iw;
      lens[t]++;
   endtask

   // Compare each registered decode word with the model
   always @(negedge clk) begin
      if (!rstN) begin
         expPc    = `RESET_PC;
         haltSeen = 1'b0;
         lastDec  = '0;
      end else begin
         lastDec = decOut;
         if (decOut.valid) begin
            assert (!haltSeen) else begin
               $display("%s: a valid word came out after HALT", testName);
               errCnt++;
            end
            w = prog[expPc[6:1]];
            checkWord("pcPlus2", expPc + 16'd2, decOut.pcPlus2);
            checkWord("instr", w, decOut.instr);
            checkWord("rsData", mRegs[w[10:8]], decOut.rsData);
            checkWord("rtData", mRegs[w[7:5]], decOut.rtData);
            checkWord("imm", extImm(w), decOut.imm);
            if (w[15:11] == 5'b00000) begin
               assert (halted) else begin
                  $display("%s: halted did not rise with the HALT word", testName);
                  errCnt++;
               end
               haltSeen = 1'b1;
            end
            lastPc2 = expPc + 16'd2;
            lastImm = extImm(w);
            expPc   = nextPc(w, expPc, mRegs[w[10:8]]);
            wordCnt++;
         end
      end
   end

   // Execute/writeback model, one cycle behind decOut
   always @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            mRegs[i] <= '0;
         end
         wb <= '0;
      end else begin
         if (wb.en) begin
            mRegs[wb.addr] <= pendVal;          // Same edge as the DUT write
         end
         op = lastDec.instr[15:11];
         wb.en      <= 1'b0;
         wb.imm     <= lastImm;
         wb.pcPlus2 <= lastPc2;
         wb.aluData <= 16'($random(seed));
         if (lastDec.valid) begin
            if (op == 5'b11000) begin           // LBI writes rs
               wb.en    <= 1'b1;
               wb.addr  <= lastDec.instr[10:8];
               wb.src   <= srcImm;
               pendVal  <= lastImm;
            end else if (op == 5'b00110 || op == 5'b00111) begin
               wb.en    <= 1'b1;
               wb.addr  <= 3'd7;
               wb.src   <= srcLink;
               pendVal  <= lastPc2;
            end else if (op[4:2] != 3'b000 && op[4:2] != 3'b001 && op[4:2] != 3'b011) begin
               aluVal = 16'($random(seed));     // ALU class result
               wb.en      <= 1'b1;
               wb.addr    <= (op[4:3] == 2'b11) ? lastDec.instr[4:2] : lastDec.instr[7:5];
               wb.src     <= srcAlu;
               wb.aluData <= aluVal;
               pendVal    <= aluVal;
            end
         end
      end
   end

   task automatic buildPrograms();
      logic [4:0] bops [4];
      bops = '{5'b01100, 5'b01101, 5'b01110, 5'b01111};
      names = '{"straight", "regPath", "wbSelect", "branches", "jumps", "halt"};
      for (int t = 0; t < testCnt; t++) begin
         lens[t] = 0;
         for (int a = 0; a < `IMEM_DEPTH; a++) begin
            progs[t][a] = {5'b00000, 11'(a)};  // HALT carrying its own address
         end
      end
      put(0, {5'b00001, 11'd0});
      put(0, {addiOp, 3'd0, 3'd1, 5'd3});
      put(0, {addiOp, 3'd1, 3'd2, 5'h1f});
      put(0, {5'b01010, 3'd2, 3'd3, 5'h1f});
      put(0, {5'b00001, 11'd0});
      put(0, {5'b01011, 3'd3, 3'd4, 5'h11});
      put(0, {addiOp, 3'd4, 3'd5, 5'h10});
      put(0, 16'h0000);
      for (int i = 1; i < 7; i++) begin           // Chained reads hit the bypass on both ports
         put(1, {addOp, 3'(i), 3'(i - 1), 3'(i), 2'd0});
         put(1, {addiOp, 3'(i), 3'(i + 1), 5'd1});
      end
      put(1, 16'h0000);
      put(2, {5'b11000, 3'd1, 8'hfb});
      put(2, {5'b00110, 11'd0});
      put(2, {addiOp, 3'd0, 3'd2, 5'd9});
      put(2, {5'b00001, 11'd0});
      put(2, {5'b00001, 11'd0});
      put(2, {addOp, 3'd1, 3'd7, 3'd3, 2'd0});
      put(2, {addOp, 3'd2, 3'd1, 3'd4, 2'd0});
      put(2, 16'h0000);
      put(3, {5'b11000, 3'd1, 8'h00});
      put(3, {5'b11000, 3'd2, 8'h05});
      put(3, {5'b11000, 3'd3, 8'hfd});
      put(3, {5'b00001, 11'd0});
      put(3, {5'b00001, 11'd0});
      for (int b = 0; b < 4; b++) begin
         for (int r = 1; r < 4; r++) begin
            put(3, {bops[b], 3'(r), 8'd2});   // Taken skips the filler
            put(3, {addiOp, 3'd5, 3'd5, 5'd1});
         end
      end
      put(3, 16'h0000);
      put(4, {5'b00100, 11'd2});
      put(4, {addiOp, 3'd5, 3'd5, 5'd1});
      put(4, {5'b00110, 11'd2});
      put(4, {addiOp, 3'd5, 3'd5, 5'd1});
      put(4, {5'b11000, 3'd4, 8'd14});
      put(4, {5'b00001, 11'd0});
      put(4, {5'b00001, 11'd0});
      put(4, {5'b00101, 3'd4, 8'd4});
      put(4, {addiOp, 3'd5, 3'd5, 5'd1});
      put(4, {5'b11000, 3'd6, 8'd20});
      put(4, {5'b00001, 11'd0});
      put(4, {5'b00001, 11'd0});
      put(4, {5'b00111, 3'd6, 8'd8});
      put(4, {addiOp, 3'd5, 3'd5, 5'd1});
      put(4, {addOp, 3'd7, 3'd0, 3'd1, 2'd0});
      put(4, 16'h0000);
      put(5, {5'b00001, 11'd0});
      put(5, 16'h0000);
      for (int i = 0; i < 3; i++) begin            // Must never reach decOut
         put(5, {addiOp, 3'd5, 3'd5, 5'd1});
      end
   endtask

   task automatic runTest(input int t);
      int startErr;
      startErr = errCnt;
      testName = names[t];
      wordCnt  = 0;
      prog     = progs[t];
      @(posedge clk);
      rstN <= 1'b0;
      run  <= 1'b0;
      repeat (2) @(posedge clk);
      rstN <= 1'b1;
      for (int a = 0; a < `IMEM_DEPTH; a++) begin
         imemWr <= '{en: 1'b1, addr: imemAddrW'(a), data: progs[t][a]};
         @(posedge clk);
      end
      imemWr <= '0;
      run    <= 1'b1;
      wait (haltSeen);
      repeat (10) @(posedge clk);                  // Idle window after HALT
      run <= 1'b0;
      if (errCnt == startErr) begin
         passCnt++;
         $display("Test %s: ok, %0d words checked", testName, wordCnt);
      end else begin
         failCnt++;
         $display("Test %s: %0d errors", testName, errCnt - startErr);
      end
   endtask

   // Stops a run that never reaches HALT
   initial begin
      int work;
      wait (setupDone);
      work = 0;
      for (int t = 0; t < testCnt; t++) begin
         work += lens[t] + `IMEM_DEPTH + 16;
      end
      repeat (work * 20) @(posedge clk);
      $display("Watchdog: the tests did not finish in %0d cycles", work * 20);
      $display("Regression failed");
      $finish;
   end

   initial begin
      seed   = 32'h8b64_fb77;
      rstN   <= 1'b0;
      run    <= 1'b0;
      imemWr <= '0;
      buildPrograms();
      setupDone = 1'b1;
      for (int t = 0; t < testCnt; t++) begin
         runTest(t);
      end
      $display("Tests passed %0d, failed %0d, errors %0d", passCnt, failCnt, errCnt);
      if (errCnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+hw
hw/isaPkg.sv
hw/pipePkg.sv
hw/regFile.sv
hw/immExtend.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/wiscFrontEnd.sv
tests/tbFrontEnd.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tbFrontEnd -f list.f > build.log 2>&1 \
   && ./obj_dir/VtbFrontEnd > sim.log 2>&1 \
   || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
